//--- common/soc_config.svh
// Build-time widths, address map and counter lengths of the system-control core
// Included by the package and by every module that sizes a port or a counter
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SOC_ARCHBITSZ 32 // Data word
`define SOC_ADDRBITSZ 30 // Word address, byte bits dropped
`define SOC_SELBITSZ  4  // One enable per byte lane

`define SOC_GPIOCOUNT 8

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address map, sizes in words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Device table sits at word 0 and GPIO right after it
`define SOC_DEVTBL_MAPSZ 64
`define SOC_GPIO_MAPSZ   64
`define SOC_DEVCOUNT     2 // Mapped devices reported by the table

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define SOC_RST_CYCLES     16 // Reset hold
`define SOC_ACT_CNTR_BITSZ 7  // Activity light off-time

`endif

//--- common/soc_pkg.sv
// Bus operation, slave index and data types of the peripheral bus
// Referenced by scoped name from the modules
`include "soc_config.svh"

package soc_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bus request
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [1:0] {
		OP_NONE = 2'b00, // Idle cycle
		OP_WR   = 2'b01,
		OP_RD   = 2'b10,
		OP_RDWR = 2'b11  // Returns old value, writes new one
	} pi1_op_t;

	typedef logic [`SOC_ARCHBITSZ-1:0] word_t;
	typedef logic [`SOC_ADDRBITSZ-1:0] waddr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Slaves
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Order follows the address map
	typedef enum logic [1:0] {
		SL_DEVTBL  = 2'd0,
		SL_GPIO    = 2'd1,
		SL_INVALID = 2'd2 // Default slave, reads zero
	} slave_idx_t;

endpackage

//--- logic/reset_seq.sv
// Power-on and software reset sequencer; drives the system reset of every block
// from rst_p and the devtbl command bits (rst1 warm, both cold, rst0 power-off)
`timescale 1ns/1ns
`include "soc_config.svh"

module reset_seq (
	input  logic clk100mhz,
	input  logic rst_p,
	input  logic rst0_i,
	input  logic rst1_i,
	output logic sys_rst_o
);
	localparam int CNTR_BITSZ = $clog2(`SOC_RST_CYCLES + 1);

	logic [1:0]            cmd_q; // {rst1, rst0} one stage late
	logic [CNTR_BITSZ-1:0] cntr;
	logic                  pwroff_q;
	logic                  reload;
	logic                  pwroff;

	assign reload = cmd_q[1]; // Cold acts as warm
	assign pwroff = cmd_q[0] && !cmd_q[1];

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			cmd_q     <= 2'b00;
			cntr      <= CNTR_BITSZ'(`SOC_RST_CYCLES);
			pwroff_q  <= 1'b0;
			sys_rst_o <= 1'b1;
		end else begin
			cmd_q <= {rst1_i, rst0_i};
			if (reload)
				cntr <= CNTR_BITSZ'(`SOC_RST_CYCLES);
			else if (cntr != '0)
				cntr <= cntr - 1'b1;
			if (pwroff)
				pwroff_q <= 1'b1; // Only rst_p gets out of this
			sys_rst_o <= reload || pwroff || pwroff_q || (cntr != '0);
		end
	end

endmodule

//--- logic/activity_led.sv
// Activity light stretcher; one pulse per burst of bus traffic,
// then a dead time of all-ones counter cycles
`timescale 1ns/1ns
`include "soc_config.svh"

module activity_led (
	input  logic clk100mhz,
	input  logic rst_p,
	input  logic trig_i,
	output logic activity_o
);
	logic [`SOC_ACT_CNTR_BITSZ-1:0] cntr;

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			cntr       <= '0;
			activity_o <= 1'b0;
		end else if (cntr != '0) begin
			activity_o <= 1'b0; // Triggers ignored while running down
			cntr       <= cntr - 1'b1;
		end else begin
			activity_o <= trig_i;
			if (trig_i)
				cntr <= '1;
		end
	end

endmodule

//--- bus/pi1_decoder.sv
// Address decoder of the peripheral bus; picks the slave for each request
// and hands the slaves a request strobe and a word offset
`timescale 1ns/1ns
`include "soc_config.svh"

module pi1_decoder (
	input  logic                                 clk100mhz,
	input  logic                                 sys_rst_i,
	input  soc_pkg::pi1_op_t                     pi1_op_i,
	input  soc_pkg::waddr_t                      pi1_addr_i,
	output logic                                 dt_req_o,
	output logic                                 gp_req_o,
	output soc_pkg::slave_idx_t                  idx_o,
	output logic                                 acc_o,
	output logic [$clog2(`SOC_DEVTBL_MAPSZ)-1:0] offs_o
);
	localparam int DT_BASE = 0;
	localparam int GP_BASE = DT_BASE + `SOC_DEVTBL_MAPSZ;

	soc_pkg::waddr_t dt_rel;
	soc_pkg::waddr_t gp_rel;
	logic            dt_hit;
	logic            gp_hit;

	// Addresses below a base wrap around and fail the size compare
	assign dt_rel = pi1_addr_i - soc_pkg::waddr_t'(DT_BASE);
	assign gp_rel = pi1_addr_i - soc_pkg::waddr_t'(GP_BASE);
	assign dt_hit = dt_rel < soc_pkg::waddr_t'(`SOC_DEVTBL_MAPSZ);
	assign gp_hit = gp_rel < soc_pkg::waddr_t'(`SOC_GPIO_MAPSZ);

	always_comb begin
		idx_o  = soc_pkg::SL_INVALID;
		offs_o = '0;
		if (dt_hit) begin
			idx_o  = soc_pkg::SL_DEVTBL;
			offs_o = dt_rel[$bits(offs_o)-1:0];
		end else if (gp_hit) begin
			idx_o  = soc_pkg::SL_GPIO;
			offs_o = gp_rel[$bits(offs_o)-1:0];
		end
	end

	assign acc_o    = (pi1_op_i != soc_pkg::OP_NONE) && !sys_rst_i; // Dropped in reset
	assign dt_req_o = acc_o && dt_hit;
	assign gp_req_o = acc_o && gp_hit;

	// Map windows must not overlap
	a_one_slave : assert property (@(posedge clk100mhz) !(dt_req_o && gp_req_o))
		else $error("both slaves selected at once");

endmodule

//--- bus/pi1_resp_mux.sv
// Registered response side of the bus; lines up the slave index with the
// slave's registered read data and returns it two cycles after the request
`timescale 1ns/1ns

module pi1_resp_mux (
	input  logic                clk100mhz,
	input  logic                sys_rst_i,
	input  logic                acc_i,
	input  soc_pkg::slave_idx_t idx_i,
	input  soc_pkg::word_t      dt_data_i,
	input  soc_pkg::word_t      gp_data_i,
	output soc_pkg::word_t      pi1_data_o,
	output logic                pi1_rdy_o
);
	logic                acc_q;
	soc_pkg::slave_idx_t idx_q; // Matches the slave data stage
	soc_pkg::word_t      sel_data;

	always_comb begin
		case (idx_q)
			soc_pkg::SL_DEVTBL: sel_data = dt_data_i;
			soc_pkg::SL_GPIO:   sel_data = gp_data_i;
			default:            sel_data = '0; // Unmapped reads zero
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Two stages, so two requests in flight
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i) begin
			acc_q     <= 1'b0;
			pi1_rdy_o <= 1'b0;
		end else begin
			acc_q     <= acc_i;
			pi1_rdy_o <= acc_q;
		end
	end

	always_ff @(posedge clk100mhz) begin
		idx_q      <= idx_i;
		pi1_data_o <= acc_q ? sel_data : '0;
	end

	// The reset sequencer raises sys_rst late enough for the command write's own reply
	a_no_rdy_in_rst : assert property (@(posedge clk100mhz) sys_rst_i |-> !pi1_rdy_o)
		else $error("bus response during system reset");

endmodule

//--- dev/devtbl.sv
// Device table slave; reports the device count and map sizes and holds
// the software reset command bits for the reset sequencer
`timescale 1ns/1ns
`include "soc_config.svh"

module devtbl (
	input  logic                                 clk100mhz,
	input  logic                                 sys_rst_i,
	input  logic                                 req_i,
	input  soc_pkg::pi1_op_t                     op_i,
	input  logic [$clog2(`SOC_DEVTBL_MAPSZ)-1:0] offs_i,
	input  soc_pkg::word_t                       data_i,
	input  logic [`SOC_SELBITSZ-1:0]             sel_i,
	output soc_pkg::word_t                       data_o,
	output logic                                 rst0_o,
	output logic                                 rst1_o
);
	localparam int OFFS_BITSZ = $clog2(`SOC_DEVTBL_MAPSZ);
	localparam logic [OFFS_BITSZ-1:0] REG_DEVCOUNT = 0;
	localparam logic [OFFS_BITSZ-1:0] REG_DTSZ     = 1;
	localparam logic [OFFS_BITSZ-1:0] REG_GPSZ     = 2;
	localparam logic [OFFS_BITSZ-1:0] REG_RSTCMD   = 3; // Write only

	logic [1:0]     cmd_q;
	logic           is_rd;
	logic           is_wr;
	soc_pkg::word_t rd_word;

	assign is_rd = (op_i == soc_pkg::OP_RD) || (op_i == soc_pkg::OP_RDWR);
	assign is_wr = (op_i == soc_pkg::OP_WR) || (op_i == soc_pkg::OP_RDWR);

	always_comb begin
		case (offs_i)
			REG_DEVCOUNT: rd_word = soc_pkg::word_t'(`SOC_DEVCOUNT);
			REG_DTSZ:     rd_word = soc_pkg::word_t'(`SOC_DEVTBL_MAPSZ);
			REG_GPSZ:     rd_word = soc_pkg::word_t'(`SOC_GPIO_MAPSZ);
			default:      rd_word = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i)
			cmd_q <= 2'b00;
		else if (req_i && is_wr && (offs_i == REG_RSTCMD) && sel_i[0])
			cmd_q <= data_i[1:0];
	end

	always_ff @(posedge clk100mhz) begin
		if (req_i)
			data_o <= is_rd ? rd_word : '0;
	end

	assign rst1_o = cmd_q[1];
	assign rst0_o = cmd_q[0];

endmodule

//--- dev/gpio_regs.sv
// GPIO slave; word 0 reads the synchronized input pins,
// word 1 is the output register
`timescale 1ns/1ns
`include "soc_config.svh"

module gpio_regs (
	input  logic                               clk100mhz,
	input  logic                               sys_rst_i,
	input  logic                               req_i,
	input  soc_pkg::pi1_op_t                   op_i,
	input  logic [$clog2(`SOC_GPIO_MAPSZ)-1:0] offs_i,
	input  soc_pkg::word_t                     data_i,
	input  logic [`SOC_SELBITSZ-1:0]           sel_i,
	input  logic [`SOC_GPIOCOUNT-1:0]          gpio_i,
	output soc_pkg::word_t                     data_o,
	output logic [`SOC_GPIOCOUNT-1:0]          gpio_o
);
	localparam int OFFS_BITSZ = $clog2(`SOC_GPIO_MAPSZ);
	localparam int PAD_BITSZ  = `SOC_ARCHBITSZ - `SOC_GPIOCOUNT;
	localparam logic [OFFS_BITSZ-1:0] REG_IN  = 0;
	localparam logic [OFFS_BITSZ-1:0] REG_OUT = 1;

	logic [`SOC_GPIOCOUNT-1:0] sync1;
	logic [`SOC_GPIOCOUNT-1:0] sync2;
	logic                      is_rd;
	logic                      is_wr;
	soc_pkg::word_t            rd_word;

	assign is_rd = (op_i == soc_pkg::OP_RD) || (op_i == soc_pkg::OP_RDWR);
	assign is_wr = (op_i == soc_pkg::OP_WR) || (op_i == soc_pkg::OP_RDWR);

	always_ff @(posedge clk100mhz) begin
		sync1 <= gpio_i; // Pins are asynchronous
		sync2 <= sync1;
	end

	always_comb begin
		case (offs_i)
			REG_IN:  rd_word = {{PAD_BITSZ{1'b0}}, sync2};
			REG_OUT: rd_word = {{PAD_BITSZ{1'b0}}, gpio_o};
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk100mhz) begin
		if (sys_rst_i)
			gpio_o <= '0;
		else if (req_i && is_wr && (offs_i == REG_OUT) && sel_i[0])
			gpio_o <= data_i[`SOC_GPIOCOUNT-1:0];
	end

	// Read samples gpio_o before the write lands, so RDWR returns the old value
	always_ff @(posedge clk100mhz) begin
		if (req_i)
			data_o <= is_rd ? rd_word : '0;
	end

endmodule

//--- logic/soc_top.sv
// System-control core: bus decode, devtbl and GPIO slaves, response mux,
// reset sequencer and activity light; the bus master sits outside
`timescale 1ns/1ns
`include "soc_config.svh"

module soc_top (
	input  logic                       clk100mhz,
	input  logic                       rst_p,
	input  soc_pkg::pi1_op_t           pi1_op_i,
	input  soc_pkg::waddr_t            pi1_addr_i,
	input  soc_pkg::word_t             pi1_data_i,
	input  logic [`SOC_SELBITSZ-1:0]   pi1_sel_i,
	input  logic [`SOC_GPIOCOUNT-1:0]  gpio_i,
	output soc_pkg::word_t             pi1_data_o,
	output logic                       pi1_rdy_o,
	output logic [`SOC_GPIOCOUNT-1:0]  gpio_o,
	output logic                       sys_rst_o,
	output logic                       activity_o
);
	logic sys_rst;
	logic rst0;
	logic rst1;
	logic acc;
	logic dt_req;
	logic gp_req;
	soc_pkg::slave_idx_t idx;
	logic [$clog2(`SOC_DEVTBL_MAPSZ)-1:0] offs;
	soc_pkg::word_t dt_data;
	soc_pkg::word_t gp_data;

	assign sys_rst_o = sys_rst;

	reset_seq u_reset_seq (.clk100mhz, .rst_p, .rst0_i(rst0), .rst1_i(rst1),
		.sys_rst_o(sys_rst));

	activity_led u_activity_led (.clk100mhz, .rst_p, .trig_i(acc), .activity_o);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Peripheral bus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	pi1_decoder u_pi1_decoder (.clk100mhz, .sys_rst_i(sys_rst), .pi1_op_i, .pi1_addr_i,
		.dt_req_o(dt_req), .gp_req_o(gp_req), .idx_o(idx), .acc_o(acc), .offs_o(offs));

	devtbl u_devtbl (.clk100mhz, .sys_rst_i(sys_rst), .req_i(dt_req), .op_i(pi1_op_i),
		.offs_i(offs), .data_i(pi1_data_i), .sel_i(pi1_sel_i), .data_o(dt_data),
		.rst0_o(rst0), .rst1_o(rst1));

	gpio_regs u_gpio_regs (.clk100mhz, .sys_rst_i(sys_rst), .req_i(gp_req), .op_i(pi1_op_i),
		.offs_i(offs), .data_i(pi1_data_i), .sel_i(pi1_sel_i), .gpio_i,
		.data_o(gp_data), .gpio_o);

	pi1_resp_mux u_pi1_resp_mux (.clk100mhz, .sys_rst_i(sys_rst), .acc_i(acc), .idx_i(idx),
		.dt_data_i(dt_data), .gp_data_i(gp_data), .pi1_data_o, .pi1_rdy_o);

endmodule

//--- test/tb_soc.sv
// Testbench for the system-control core; random bus requests from a fixed seed
// are checked against a bus model before the reset commands and rst_p are exercised
`timescale 1ns/1ns
`include "soc_config.svh"

module tb_soc;
	localparam int GP_BASE        = `SOC_DEVTBL_MAPSZ;
	localparam int GP_END         = GP_BASE + `SOC_GPIO_MAPSZ;
	localparam int RST_MAX        = `SOC_RST_CYCLES + 4;
	localparam int NUM_REQS       = 300;
	// Worst-case length of tests 1 to 6 in cycles
	localparam int TEST_CYCLES    = (5 + RST_MAX) + (3 * NUM_REQS + 3) + 7
		+ (130 + 1 + 127 + 3) + (2 + 2 + RST_MAX + 4)
		+ (1 + 2 + 100 + 2 + RST_MAX + 4);
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 200;

	logic                      clk100mhz;
	logic                      rst_p;
	soc_pkg::pi1_op_t          pi1_op;
	soc_pkg::waddr_t           pi1_addr;
	soc_pkg::word_t            pi1_data;
	logic [`SOC_SELBITSZ-1:0]  pi1_sel;
	logic [`SOC_GPIOCOUNT-1:0] gpio_in_val;
	soc_pkg::word_t            pi1_data_o;
	logic                      pi1_rdy_o;
	logic [`SOC_GPIOCOUNT-1:0] gpio_o;
	logic                      sys_rst_o;
	logic                      activity_o;

	int seed   = 14502;
	int cyc    = 0;
	int checks = 0;
	int errors = 0;
	int test_errs = 0;
	logic                      exp_due [8] = '{default: 1'b0}; // Slot per due cycle
	soc_pkg::word_t            exp_word [8];
	logic [`SOC_GPIOCOUNT-1:0] gpio_model;

	soc_top soc_top_inst (.clk100mhz, .rst_p, .pi1_op_i(pi1_op), .pi1_addr_i(pi1_addr),
		.pi1_data_i(pi1_data), .pi1_sel_i(pi1_sel), .gpio_i(gpio_in_val), .pi1_data_o,
		.pi1_rdy_o, .gpio_o, .sys_rst_o, .activity_o);

	initial begin
		clk100mhz = 1'b0;
		forever #5 clk100mhz = ~clk100mhz;
	end

	always @(posedge clk100mhz)
		cyc <= cyc + 1;

	initial begin
		wait (cyc >= TIMEOUT_CYCLES);
		$display("timeout: run stopped after %0d cycles", cyc);
		$display("STATUS: FAIL");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks and bus model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cyc);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("%s (cycle %0d)", msg, cyc);
	endtask

	// One cycle with the response checked mid-cycle; returns 1 ns after the next edge
	task automatic step();
		@(negedge clk100mhz);
		check("pi1_rdy_o", 32'(pi1_rdy_o), 32'(exp_due[3'(cyc)]));
		if (exp_due[3'(cyc)])
			check("pi1_data_o", pi1_data_o, exp_word[3'(cyc)]);
		@(posedge clk100mhz);
		#1;
		exp_due[3'(cyc + 2)] = 1'b0;
	endtask

	task automatic drive_req(input soc_pkg::pi1_op_t op, input soc_pkg::waddr_t addr,
			input soc_pkg::word_t data, input logic [`SOC_SELBITSZ-1:0] sel);
		pi1_op   = op;
		pi1_addr = addr;
		pi1_data = data;
		pi1_sel  = sel;
	endtask

	task automatic drive_idle();
		drive_req(soc_pkg::OP_NONE, '0, '0, '0);
	endtask

	function automatic soc_pkg::word_t model_read(input soc_pkg::waddr_t addr);
		int a;
		a = int'(addr);
		if (a == 0)
			return soc_pkg::word_t'(`SOC_DEVCOUNT);
		if (a == 1)
			return soc_pkg::word_t'(`SOC_DEVTBL_MAPSZ);
		if (a == 2)
			return soc_pkg::word_t'(`SOC_GPIO_MAPSZ);
		if (a == GP_BASE)
			return soc_pkg::word_t'(gpio_in_val);
		if (a == GP_BASE + 1)
			return soc_pkg::word_t'(gpio_model);
		return '0; // Spare words and unmapped space
	endfunction

	// Drives one request and books its response two cycles ahead
	task automatic issue(input soc_pkg::pi1_op_t op, input soc_pkg::waddr_t addr,
			input soc_pkg::word_t data, input logic [`SOC_SELBITSZ-1:0] sel);
		logic [2:0] slot;
		slot = 3'(cyc + 2);
		check("gpio_o", 32'(gpio_o), 32'(gpio_model));
		exp_word[slot] = '0;
		if (op == soc_pkg::OP_RD || op == soc_pkg::OP_RDWR)
			exp_word[slot] = model_read(addr); // Old value before any write
		if ((op == soc_pkg::OP_WR || op == soc_pkg::OP_RDWR) &&
				int'(addr) == GP_BASE + 1 && sel[0])
			gpio_model = data[`SOC_GPIOCOUNT-1:0];
		exp_due[slot] = 1'b1;
		drive_req(op, addr, data, sel);
	endtask

	task automatic rand_req(output soc_pkg::pi1_op_t op, output soc_pkg::waddr_t addr,
			output soc_pkg::word_t data, output logic [`SOC_SELBITSZ-1:0] sel);
		logic [31:0] r;
		logic [31:0] offs;
		r    = $random(seed);
		data = $random(seed);
		offs = r[9] ? 32'(r[11:10]) : 32'(r[15:10]); // Low words more often
		case (r[17:16])
			2'd0:    op = soc_pkg::OP_WR;
			2'd1:    op = soc_pkg::OP_RDWR;
			default: op = soc_pkg::OP_RD;
		endcase
		case (r[19:18])
			2'd0:       addr = soc_pkg::waddr_t'(offs);
			2'd1, 2'd2: addr = soc_pkg::waddr_t'(GP_BASE + offs);
			default:    addr = r[20] ? '1 : soc_pkg::waddr_t'(GP_END + 32'(r[31:21]));
		endcase
		sel = r[25:22];
		if (int'(addr) == 3)
			data[1:0] = 2'b00; // Keeps the reset command idle
	endtask

	task automatic wait_sys_rst(input logic level, input int max_cycles, output int n);
		n = 0;
		while (sys_rst_o !== level && n < max_cycles) begin
			step();
			n++;
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, errors - test_errs);
		test_errs = errors;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin : main
		int                       i;
		int                       n;
		logic [31:0]              r;
		soc_pkg::pi1_op_t         op;
		soc_pkg::waddr_t          addr;
		soc_pkg::word_t           data;
		logic [`SOC_SELBITSZ-1:0] sel;

		rst_p       = 1'b1;
		gpio_in_val = 8'h5a;
		gpio_model  = '0;
		drive_idle();
		repeat (5) @(posedge clk100mhz);
		#1;
		rst_p = 1'b0;
		wait_sys_rst(1'b0, RST_MAX, n);
		if (sys_rst_o !== 1'b0)
			note_failure("sys_rst_o still high after the power-on reset");
		check("pi1_rdy_o", 32'(pi1_rdy_o), 32'd0);
		check("gpio_o", 32'(gpio_o), 32'd0);
		check("activity_o", 32'(activity_o), 32'd0);
		end_test(1, "power-on reset");

		for (i = 0; i < NUM_REQS; i++) begin
			rand_req(op, addr, data, sel);
			issue(op, addr, data, sel);
			step();
			r = $random(seed);
			if (r[1:0] == 2'd0) begin // Mostly back-to-back
				drive_idle();
				repeat (r[2] ? 2 : 1) step();
			end
		end
		drive_idle();
		repeat (3) step();
		check("gpio_o", 32'(gpio_o), 32'(gpio_model));
		end_test(2, "random bus traffic");

		r = $random(seed);
		gpio_in_val = r[7:0];
		repeat (3) step();
		issue(soc_pkg::OP_RD, soc_pkg::waddr_t'(GP_BASE), '0, '0);
		step();
		drive_idle();
		repeat (3) step();
		end_test(3, "gpio input read");

		repeat (130) step(); // Counter drains
		check("activity_o", 32'(activity_o), 32'd0);
		issue(soc_pkg::OP_RD, soc_pkg::waddr_t'(0), '0, '0);
		step();
		check("activity_o", 32'(activity_o), 32'd1);
		for (i = 0; i < 127; i++) begin
			issue(soc_pkg::OP_RD, soc_pkg::waddr_t'(1), '0, '0);
			step();
			check("activity_o", 32'(activity_o), 32'd0);
		end
		drive_idle();
		repeat (3) step();
		end_test(4, "activity light");

		issue(soc_pkg::OP_WR, soc_pkg::waddr_t'(GP_BASE + 1), 32'h0000_00a5, 4'h1);
		step();
		issue(soc_pkg::OP_WR, soc_pkg::waddr_t'(3), 32'h2, 4'h1); // Warm
		step();
		drive_idle();
		wait_sys_rst(1'b1, 2, n); // Counted from the cycle after the write
		if (sys_rst_o !== 1'b1)
			note_failure("sys_rst_o did not rise after the warm reset command");
		gpio_model = '0;
		wait_sys_rst(1'b0, RST_MAX, n);
		if (sys_rst_o !== 1'b0 || n < `SOC_RST_CYCLES)
			note_failure($sformatf("sys_rst_o fell after %0d cycles, outside %0d to %0d",
				n, `SOC_RST_CYCLES, RST_MAX));
		issue(soc_pkg::OP_RD, soc_pkg::waddr_t'(GP_BASE + 1), '0, '0);
		step();
		drive_idle();
		repeat (3) step();
		end_test(5, "warm reset command");

		issue(soc_pkg::OP_WR, soc_pkg::waddr_t'(3), 32'h1, 4'h1); // Power-off
		step();
		drive_idle();
		wait_sys_rst(1'b1, 2, n);
		if (sys_rst_o !== 1'b1)
			note_failure("sys_rst_o did not rise after the power-off command");
		gpio_model = '0;
		for (i = 0; i < 100; i++) begin
			rand_req(op, addr, data, sel);
			drive_req(op, addr, data, sel); // Dropped with no response due
			step();
			check("sys_rst_o", 32'(sys_rst_o), 32'd1);
		end
		drive_idle();
		rst_p = 1'b1;
		repeat (2) step();
		rst_p = 1'b0;
		wait_sys_rst(1'b0, RST_MAX, n);
		if (sys_rst_o !== 1'b0)
			note_failure("sys_rst_o still high after the rst_p pulse");
		issue(soc_pkg::OP_RD, soc_pkg::waddr_t'(1), '0, '0);
		step();
		drive_idle();
		repeat (3) step();
		end_test(6, "power-off and rst_p");

		$display("6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

//--- compile.f
+incdir+common
common/soc_pkg.sv
logic/reset_seq.sv
logic/activity_led.sv
bus/pi1_decoder.sv
bus/pi1_resp_mux.sv
dev/devtbl.sv
dev/gpio_regs.sv
logic/soc_top.sv
test/tb_soc.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_soc
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJDIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
